//--- include/cdi_loader_settings.svh
`ifndef CDI_LOADER_SETTINGS_SVH
`define CDI_LOADER_SETTINGS_SVH

// ========================================
// Address and data widths
// ========================================

// SDRAM byte address
`define CDI_SDRAM_ADDR_W 25

// Byte address from the host loader
`define CDI_DL_ADDR_W 25

// Slave controller write-once memory
`define CDI_WORM_ADDR_W 13

// ========================================
// Image routing and RAM zeroing
// ========================================

// Top three SDRAM address bits of the boot ROM
`define CDI_ROM_REGION 3'b001

// Index bit set for the slave image, clear for the main boot ROM
`define CDI_WORM_INDEX_BIT 6

// 512k words, 1 MB of RAM
`define CDI_ZERO_WORDS_LOG2 19

`endif

//--- source/cdi_loader_pkg.sv
`include "cdi_loader_settings.svh"

package cdi_loader_pkg;

    // ========================================
    // SDRAM side
    // ========================================

    typedef logic [`CDI_SDRAM_ADDR_W-1:0] sdram_addr_t;
    typedef logic [15:0] sdram_word_t;

    // ========================================
    // Slave controller memory
    // ========================================

    typedef logic [`CDI_WORM_ADDR_W-1:0] worm_addr_t;
    typedef logic [7:0] worm_byte_t;

    // One download word, seen as a ROM word or as two slave memory bytes
    typedef union packed {
        sdram_word_t word;
        struct packed {
            worm_byte_t hi;
            worm_byte_t lo;
        } bytes;
    } dl_word_u;

    // Owner of the SDRAM port while the core is held in reset
    // Highest priority first
    typedef enum logic [1:0] {
        ROM_DOWNLOAD,
        RAM_ZERO,
        REFRESH,
        IDLE
    } sdram_owner_e;

endpackage

//--- source/rom_wr_if.sv
interface rom_wr_if import cdi_loader_pkg::*; ();

    logic        pending;
    sdram_addr_t addr;
    sdram_word_t data;
    logic        done;

    modport latch (
        output pending, addr, data,
        input  done
    );

    // done pulses when the SDRAM finishes the ROM write
    modport sequencer (
        input  pending, addr, data,
        output done
    );

endinterface

//--- source/download_decoder.sv
`include "cdi_loader_settings.svh"

module download_decoder import cdi_loader_pkg::*; (
    input  logic                      clk_sys,
    input  logic                      rst,
    input  logic                      dl_wr,
    input  logic [15:0]               dl_index,
    input  logic [`CDI_DL_ADDR_W-1:0] dl_addr,
    input  dl_word_u                  dl_data,
    output logic                      rom_req,
    output sdram_addr_t               rom_req_addr,
    output sdram_word_t               rom_req_data,
    output logic                      worm_wr,
    output worm_addr_t                worm_addr,
    output worm_byte_t                worm_data
);

    logic       is_worm;
    logic       worm_strobe;
    logic       worm_strobe_q;
    worm_byte_t worm_hi_q;

    assign is_worm     = dl_index[`CDI_WORM_INDEX_BIT];
    assign worm_strobe = dl_wr && is_worm;

    // ========================================
    // Main boot ROM words
    // ========================================

    assign rom_req = dl_wr && !is_worm;

    // Word address placed in the ROM region, always word aligned
    assign rom_req_addr = {`CDI_ROM_REGION, dl_addr[`CDI_SDRAM_ADDR_W-4:1], 1'b0};

    // Host sends little endian, the 68k wants big endian
    assign rom_req_data = {dl_data.word[7:0], dl_data.word[15:8]};

    // ========================================
    // Slave memory byte split
    // ========================================

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            worm_strobe_q <= 1'b0;
            worm_wr       <= 1'b0;
        end else begin
            worm_strobe_q <= worm_strobe;
            worm_wr       <= worm_strobe || worm_strobe_q;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (worm_strobe) begin
            // Low byte goes out first, high byte waits a cycle
            worm_addr <= dl_addr[`CDI_WORM_ADDR_W-1:0];
            worm_data <= dl_data.bytes.lo;
            worm_hi_q <= dl_data.bytes.hi;
        end else begin
            worm_addr[0] <= 1'b1;
            worm_data    <= worm_hi_q;
        end
    end

    // Slave words must be spaced by at least two idle cycles
    a_worm_pair_only: assert property (
        @(posedge clk_sys) disable iff (rst)
        worm_wr [*2] |=> !worm_wr
    );

endmodule

//--- source/rom_word_latch.sv
module rom_word_latch import cdi_loader_pkg::*; (
    input  logic        clk_sys,
    input  logic        rst,
    input  logic        rom_req,
    input  sdram_addr_t rom_req_addr,
    input  sdram_word_t rom_req_data,
    rom_wr_if.latch     rd_port,
    output logic        download_overflow
);

    logic accept;

    // Only one word can wait for the SDRAM
    assign accept = rom_req && !rd_port.pending;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            rd_port.pending   <= 1'b0;
            download_overflow <= 1'b0;
        end else begin
            if (accept) begin
                rd_port.pending <= 1'b1;
            end else if (rd_port.done) begin
                rd_port.pending <= 1'b0;
            end

            // Word lost, sticky until reset
            if (rom_req && rd_port.pending) begin
                download_overflow <= 1'b1;
            end
        end
    end

    // ========================================
    // Pending word payload
    // ========================================

    always_ff @(posedge clk_sys) begin
        if (accept) begin
            rd_port.addr <= rom_req_addr;
            rd_port.data <= rom_req_data;
        end
    end

    // The sequencer only completes a write the latch has handed over
    a_done_while_pending: assert property (
        @(posedge clk_sys) disable iff (rst)
        rd_port.done |-> rd_port.pending
    );

endmodule

//--- source/prep_sequencer.sv
`include "cdi_loader_settings.svh"

module prep_sequencer import cdi_loader_pkg::*; #(
    parameter int zero_words_log2 = `CDI_ZERO_WORDS_LOG2
) (
    input  logic        clk_sys,
    input  logic        rst,
    input  logic        reset_req,
    input  logic        user_button,
    input  logic        dl_active,
    rom_wr_if.sequencer rom_port,
    input  sdram_addr_t core_addr,
    input  sdram_word_t core_din,
    input  logic        core_rd,
    input  logic        core_wr,
    input  logic        core_word,
    input  logic        core_refresh,
    input  logic        core_burst,
    output sdram_addr_t sdram_addr,
    output sdram_word_t sdram_din,
    output logic        sdram_rd,
    output logic        sdram_wr,
    output logic        sdram_word,
    output logic        sdram_refresh,
    output logic        sdram_burst,
    input  logic        sdram_busy,
    output logic        core_reset
);

    // Top bit marks zeroing as finished
    logic [zero_words_log2:0] zero_cnt;
    logic                     zero_done;
    logic                     dl_active_q;
    logic                     dl_start;
    logic                     busy_q;
    logic                     busy_fall;
    logic                     rom_live;
    sdram_owner_e             owner;
    sdram_owner_e             owner_q;
    sdram_owner_e             owner_next;
    sdram_addr_t              prep_addr;
    sdram_word_t              prep_din;
    logic                     prep_rd;
    logic                     prep_wr;
    logic                     prep_refresh;

    assign zero_done = zero_cnt[zero_words_log2];
    assign dl_start  = dl_active && !dl_active_q;
    assign busy_fall = busy_q && !sdram_busy;

    assign rom_port.done = busy_fall && (owner_q == ROM_DOWNLOAD);

    // A word finishing right now must not be written twice
    assign rom_live = rom_port.pending && !rom_port.done;

    // ========================================
    // SDRAM owner
    // ========================================

    always_comb begin
        owner_next = IDLE;
        if (core_reset) begin
            if (rom_live) begin
                owner_next = ROM_DOWNLOAD;
            end else if (!zero_done) begin
                owner_next = RAM_ZERO;
            end else begin
                owner_next = REFRESH;
            end
        end

        // Owner stays put until the running access ends
        owner = sdram_busy ? owner_q : owner_next;
    end

    // ========================================
    // Preparation requests
    // ========================================

    always_comb begin
        prep_addr = '0;
        prep_addr[zero_words_log2:1] = zero_cnt[zero_words_log2-1:0];
        prep_din     = '0;
        prep_rd      = 1'b0;
        prep_wr      = 1'b0;
        prep_refresh = 1'b0;

        case (owner)
            ROM_DOWNLOAD: begin
                prep_addr = rom_port.addr;
                prep_din  = rom_port.data;
                prep_wr   = 1'b1;
            end
            RAM_ZERO: begin
                // Counter moves on at a busy fall, wait one cycle for it
                prep_wr = !busy_q;
            end
            REFRESH: begin
                prep_rd      = 1'b1;
                prep_refresh = 1'b1;
            end
            default: begin
            end
        endcase

        if (sdram_busy) begin
            prep_rd      = 1'b0;
            prep_wr      = 1'b0;
            prep_refresh = 1'b0;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            zero_cnt    <= {1'b1, {zero_words_log2{1'b0}}};
            dl_active_q <= 1'b0;
            busy_q      <= 1'b0;
            owner_q     <= IDLE;
            core_reset  <= 1'b1;
        end else begin
            dl_active_q <= dl_active;
            busy_q      <= sdram_busy;
            owner_q     <= owner;
            core_reset  <= reset_req || user_button || dl_active || !zero_done;

            if (dl_start) begin
                zero_cnt <= '0;
            end else if (busy_fall && owner_q == RAM_ZERO && !zero_done) begin
                zero_cnt <= zero_cnt + 1'b1;
            end
        end
    end

    // ========================================
    // Port mux
    // ========================================

    assign sdram_addr    = core_reset ? prep_addr : core_addr;
    assign sdram_din     = core_reset ? prep_din : core_din;
    assign sdram_rd      = core_reset ? prep_rd : core_rd;
    assign sdram_wr      = core_reset ? prep_wr : core_wr;
    assign sdram_word    = core_reset ? 1'b1 : core_word;
    assign sdram_refresh = core_reset ? prep_refresh : core_refresh;
    assign sdram_burst   = core_reset ? 1'b0 : core_burst;

    a_no_rd_and_wr: assert property (
        @(posedge clk_sys) disable iff (rst)
        !(sdram_rd && sdram_wr)
    );

    a_no_strobe_when_busy: assert property (
        @(posedge clk_sys) disable iff (rst)
        sdram_busy |-> !(sdram_rd || sdram_wr)
    );

endmodule

//--- source/cdi_boot_loader.sv
`include "cdi_loader_settings.svh"

module cdi_boot_loader import cdi_loader_pkg::*; #(
    parameter int zero_words_log2 = `CDI_ZERO_WORDS_LOG2
) (
    input  logic                      clk_sys,
    input  logic                      rst,
    input  logic                      reset_req,
    input  logic                      user_button,
    input  logic                      dl_active,
    input  logic                      dl_wr,
    input  logic [15:0]               dl_index,
    input  logic [`CDI_DL_ADDR_W-1:0] dl_addr,
    input  logic [15:0]               dl_data,
    input  sdram_addr_t               core_addr,
    input  sdram_word_t               core_din,
    input  logic                      core_rd,
    input  logic                      core_wr,
    input  logic                      core_word,
    input  logic                      core_refresh,
    input  logic                      core_burst,
    output sdram_addr_t               sdram_addr,
    output sdram_word_t               sdram_din,
    output logic                      sdram_rd,
    output logic                      sdram_wr,
    output logic                      sdram_word,
    output logic                      sdram_refresh,
    output logic                      sdram_burst,
    input  logic                      sdram_busy,
    output logic                      core_reset,
    output logic                      download_overflow,
    output logic                      worm_wr,
    output worm_addr_t                worm_addr,
    output worm_byte_t                worm_data
);

    logic        rom_req;
    sdram_addr_t rom_req_addr;
    sdram_word_t rom_req_data;

    rom_wr_if rom_wr ();

    download_decoder u_decoder (
        .clk_sys      (clk_sys),
        .rst          (rst),
        .dl_wr        (dl_wr),
        .dl_index     (dl_index),
        .dl_addr      (dl_addr),
        .dl_data      (dl_data),
        .rom_req      (rom_req),
        .rom_req_addr (rom_req_addr),
        .rom_req_data (rom_req_data),
        .worm_wr      (worm_wr),
        .worm_addr    (worm_addr),
        .worm_data    (worm_data)
    );

    rom_word_latch u_latch (
        .clk_sys           (clk_sys),
        .rst               (rst),
        .rom_req           (rom_req),
        .rom_req_addr      (rom_req_addr),
        .rom_req_data      (rom_req_data),
        .rd_port           (rom_wr.latch),
        .download_overflow (download_overflow)
    );

    prep_sequencer #(
        .zero_words_log2 (zero_words_log2)
    ) u_sequencer (
        .clk_sys       (clk_sys),
        .rst           (rst),
        .reset_req     (reset_req),
        .user_button   (user_button),
        .dl_active     (dl_active),
        .rom_port      (rom_wr.sequencer),
        .core_addr     (core_addr),
        .core_din      (core_din),
        .core_rd       (core_rd),
        .core_wr       (core_wr),
        .core_word     (core_word),
        .core_refresh  (core_refresh),
        .core_burst    (core_burst),
        .sdram_addr    (sdram_addr),
        .sdram_din     (sdram_din),
        .sdram_rd      (sdram_rd),
        .sdram_wr      (sdram_wr),
        .sdram_word    (sdram_word),
        .sdram_refresh (sdram_refresh),
        .sdram_burst   (sdram_burst),
        .sdram_busy    (sdram_busy),
        .core_reset    (core_reset)
    );

endmodule

//--- verif/tb_cdi_boot_loader.sv
`include "cdi_loader_settings.svh"

module tb_cdi_boot_loader import cdi_loader_pkg::*; ();

    localparam int ZERO_LOG2   = 3;
    localparam int ZERO_WORDS  = 1 << ZERO_LOG2;
    localparam int BUSY_CYCLES = 3;

    // Operation codes in the data file
    localparam logic [3:0] OP_START  = 4'h1;
    localparam logic [3:0] OP_ROM    = 4'h2;
    localparam logic [3:0] OP_WORM   = 4'h3;
    localparam logic [3:0] OP_END    = 4'h4;
    localparam logic [3:0] OP_CORE   = 4'h5;
    localparam logic [3:0] OP_DOUBLE = 4'h6;

    logic                      clk_sys;
    logic                      rst;
    logic                      reset_req;
    logic                      user_button;
    logic                      dl_active;
    logic                      dl_wr;
    logic [15:0]               dl_index;
    logic [`CDI_DL_ADDR_W-1:0] dl_addr;
    logic [15:0]               dl_data;
    sdram_addr_t               core_addr;
    sdram_word_t               core_din;
    logic                      core_rd;
    logic                      core_wr;
    logic                      core_word;
    logic                      core_refresh;
    logic                      core_burst;
    sdram_addr_t               sdram_addr;
    sdram_word_t               sdram_din;
    logic                      sdram_rd;
    logic                      sdram_wr;
    logic                      sdram_word;
    logic                      sdram_refresh;
    logic                      sdram_burst;
    logic                      sdram_busy;
    logic                      core_reset;
    logic                      download_overflow;
    logic                      worm_wr;
    worm_addr_t                worm_addr;
    worm_byte_t                worm_data;

    // Data file columns
    logic [3:0]                op_q[$];
    logic [15:0]               index_q[$];
    logic [`CDI_DL_ADDR_W-1:0] addr_q[$];
    logic [15:0]               data_q[$];
    sdram_addr_t               exp_addr_q[$];
    logic [15:0]               exp_data_q[$];

    // Writes accepted by the SDRAM model, in order
    sdram_addr_t wr_addr_q[$];
    sdram_word_t wr_data_q[$];

    logic accept_req    = 1'b0;
    int   busy_left     = 0;
    int   cycle_count   = 0;
    int   timeout_limit = 1000000;
    int   zero_first    = 0;
    int   rom_words     = 0;
    logic overflow_exp  = 1'b0;

    cdi_boot_loader #(
        .zero_words_log2 (ZERO_LOG2)
    ) DUT (.*);

    initial begin
        clk_sys = 1'b0;
        forever #5 clk_sys = ~clk_sys;
    end

    // ========================================
    // SDRAM model and run limit
    // ========================================

    always @(negedge clk_sys) begin
        if (core_reset && sdram_rd && !sdram_refresh) begin
            abort_run("A plain read reached the SDRAM while the core was held in reset");
        end
        if (!sdram_busy && (sdram_rd || sdram_wr)) begin
            accept_req = 1'b1;
            if (sdram_wr) begin
                wr_addr_q.push_back(sdram_addr);
                wr_data_q.push_back(sdram_din);
            end
        end
    end

    // Busy rises after an accepted strobe and holds for BUSY_CYCLES
    always @(posedge clk_sys) begin
        #1;
        if (busy_left > 0) begin
            busy_left = busy_left - 1;
        end
        if (accept_req) begin
            busy_left  = BUSY_CYCLES;
            accept_req = 1'b0;
        end
        sdram_busy = (busy_left > 0);
    end

    always @(posedge clk_sys) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > timeout_limit) begin
            abort_run($sformatf("Timeout, the run did not finish within %0d cycles",
                                timeout_limit));
        end
    end

    // ========================================
    // Checks
    // ========================================

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_sdram_write(input sdram_addr_t got_addr, input sdram_word_t got_data,
                                     input sdram_addr_t exp_addr, input sdram_word_t exp_data);
        if (got_addr !== exp_addr) begin
            abort_run($sformatf("FAILED at time %0t: sdram_addr expected %h, got %h",
                                $time, exp_addr, got_addr));
        end else if (got_data !== exp_data) begin
            abort_run($sformatf("FAILED at time %0t: sdram_din expected %h, got %h",
                                $time, exp_data, got_data));
        end
    endtask

    task automatic check_worm(input worm_addr_t got_addr, input worm_byte_t got_data,
                              input worm_addr_t exp_addr, input worm_byte_t exp_data);
        if (got_addr !== exp_addr) begin
            abort_run($sformatf("FAILED at time %0t: worm_addr expected %h, got %h",
                                $time, exp_addr, got_addr));
        end else if (got_data !== exp_data) begin
            abort_run($sformatf("FAILED at time %0t: worm_data expected %h, got %h",
                                $time, exp_data, got_data));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED at time %0t: %s expected %b, got %b",
                                $time, name, exp, got));
        end
    endtask

    // ========================================
    // Stimulus
    // ========================================

    task automatic next_cycle();
        @(posedge clk_sys);
        #1;
    endtask

    task automatic wait_sdram_idle();
        @(negedge clk_sys);
        while (sdram_busy) begin
            @(negedge clk_sys);
        end
        next_cycle();
    endtask

    task automatic read_test_data();
        int                        fd;
        int                        fields;
        string                     line;
        logic [3:0]                op;
        logic [15:0]               index;
        logic [`CDI_DL_ADDR_W-1:0] addr;
        logic [15:0]               data;
        sdram_addr_t               exp_addr;
        logic [15:0]               exp_data;
        fd = $fopen("verif/cdi_boot_testdata.txt", "r");
        if (fd == 0) begin
            abort_run("Cannot open the test data file verif/cdi_boot_testdata.txt");
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) != 0) begin
                    fields = $sscanf(line, "%h %h %h %h %h %h",
                                     op, index, addr, data, exp_addr, exp_data);
                    // Comment and blank lines do not scan
                    if (fields == 6) begin
                        op_q.push_back(op);
                        index_q.push_back(index);
                        addr_q.push_back(addr);
                        data_q.push_back(data);
                        exp_addr_q.push_back(exp_addr);
                        exp_data_q.push_back(exp_data);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic start_download();
        if (wr_addr_q.size() != 0) begin
            abort_run("The SDRAM saw a write before the download started");
        end
        zero_first = wr_addr_q.size();
        dl_active  = 1'b1;
        next_cycle();
    endtask

    task automatic send_rom_word(input logic [15:0] index,
                                 input logic [`CDI_DL_ADDR_W-1:0] addr,
                                 input logic [15:0] data, input sdram_addr_t exp_addr,
                                 input sdram_word_t exp_data, input logic twice);
        int first;
        dl_index = index;
        dl_addr  = addr;
        dl_data  = data;
        dl_wr    = 1'b1;
        next_cycle();
        // The next SDRAM write has to be this word
        first = wr_addr_q.size();
        if (twice) begin
            dl_addr = addr + `CDI_DL_ADDR_W'(2);
            dl_data = ~data;
            next_cycle();
        end
        dl_wr = 1'b0;
        while (wr_addr_q.size() == first) begin
            next_cycle();
        end
        check_sdram_write(wr_addr_q[first], wr_data_q[first], exp_addr, exp_data);
        // Only the first of two back to back words reaches the SDRAM
        rom_words++;
        if (twice) begin
            overflow_exp = 1'b1;
        end
        wait_sdram_idle();
    endtask

    task automatic send_worm_word(input logic [15:0] index,
                                  input logic [`CDI_DL_ADDR_W-1:0] addr,
                                  input logic [15:0] data, input worm_addr_t exp_addr,
                                  input logic [15:0] exp_data);
        dl_index = index;
        dl_addr  = addr;
        dl_data  = data;
        dl_wr    = 1'b1;
        next_cycle();
        dl_wr = 1'b0;
        @(negedge clk_sys);
        check_flag("worm_wr", worm_wr, 1'b1);
        check_worm(worm_addr, worm_data, exp_addr, exp_data[7:0]);
        @(negedge clk_sys);
        check_flag("worm_wr", worm_wr, 1'b1);
        check_worm(worm_addr, worm_data, exp_addr | worm_addr_t'(1), exp_data[15:8]);
        @(negedge clk_sys);
        check_flag("worm_wr", worm_wr, 1'b0);
        next_cycle();
    endtask

    task automatic end_download();
        int zeros;
        int roms;
        dl_active = 1'b0;
        next_cycle();
        @(negedge clk_sys);
        while (core_reset) begin
            @(negedge clk_sys);
        end
        // Zero writes live below the ROM region, in address order
        zeros = 0;
        roms  = 0;
        for (int i = zero_first; i < wr_addr_q.size(); i++) begin
            if (wr_addr_q[i][`CDI_SDRAM_ADDR_W-1 -: 3] == 3'b000) begin
                check_sdram_write(wr_addr_q[i], wr_data_q[i], sdram_addr_t'(2 * zeros), '0);
                zeros++;
            end else if (wr_addr_q[i][`CDI_SDRAM_ADDR_W-1 -: 3] == `CDI_ROM_REGION) begin
                roms++;
            end
        end
        if (zeros != ZERO_WORDS) begin
            abort_run($sformatf("Core reset dropped after %0d zero writes instead of %0d",
                                zeros, ZERO_WORDS));
        end
        if (roms != rom_words) begin
            abort_run($sformatf("The SDRAM saw %0d ROM writes for %0d ROM words",
                                roms, rom_words));
        end
        next_cycle();
    endtask

    task automatic drive_core_write(input logic [`CDI_DL_ADDR_W-1:0] addr,
                                    input logic [15:0] data, input sdram_addr_t exp_addr,
                                    input sdram_word_t exp_data);
        @(negedge clk_sys);
        while (sdram_busy) begin
            @(negedge clk_sys);
        end
        next_cycle();
        core_addr  = sdram_addr_t'(addr);
        core_din   = data;
        core_wr    = 1'b1;
        core_word  = 1'b0;
        core_burst = 1'b1;
        @(negedge clk_sys);
        check_flag("core_reset", core_reset, 1'b0);
        check_flag("sdram_wr", sdram_wr, 1'b1);
        check_flag("sdram_word", sdram_word, 1'b0);
        check_flag("sdram_burst", sdram_burst, 1'b1);
        check_sdram_write(sdram_addr, sdram_din, exp_addr, exp_data);
        next_cycle();
        core_wr    = 1'b0;
        core_word  = 1'b1;
        core_burst = 1'b0;
    endtask

    task automatic drive_core_refresh();
        wait_sdram_idle();
        core_rd      = 1'b1;
        core_refresh = 1'b1;
        @(negedge clk_sys);
        check_flag("sdram_rd", sdram_rd, 1'b1);
        check_flag("sdram_refresh", sdram_refresh, 1'b1);
        check_flag("sdram_wr", sdram_wr, 1'b0);
        next_cycle();
        core_rd      = 1'b0;
        core_refresh = 1'b0;
    endtask

    task automatic check_state();
        @(negedge clk_sys);
        check_flag("download_overflow", download_overflow, overflow_exp);
        if (dl_active) begin
            check_flag("core_reset", core_reset, 1'b1);
        end
        // Preparation mode overrides the core's word and burst
        if (core_reset) begin
            check_flag("sdram_word", sdram_word, 1'b1);
            check_flag("sdram_burst", sdram_burst, 1'b0);
        end
        next_cycle();
    endtask

    // ========================================
    // Test sequence
    // ========================================

    initial begin
        rst          = 1'b1;
        reset_req    = 1'b0;
        user_button  = 1'b0;
        dl_active    = 1'b0;
        dl_wr        = 1'b0;
        dl_index     = '0;
        dl_addr      = '0;
        dl_data      = '0;
        core_addr    = '0;
        core_din     = '0;
        core_rd      = 1'b0;
        core_wr      = 1'b0;
        core_word    = 1'b0;
        core_refresh = 1'b0;
        core_burst   = 1'b1;
        sdram_busy   = 1'b0;
        read_test_data();
        timeout_limit = 100 * op_q.size() + 200;

        repeat (4) @(posedge clk_sys);
        @(negedge clk_sys);
        check_flag("core_reset", core_reset, 1'b1);
        check_flag("download_overflow", download_overflow, 1'b0);
        check_flag("sdram_wr", sdram_wr, 1'b0);
        check_flag("worm_wr", worm_wr, 1'b0);
        next_cycle();
        rst = 1'b0;

        for (int n = 0; n < op_q.size(); n++) begin
            case (op_q[n])
                OP_START: start_download();
                OP_ROM: send_rom_word(index_q[n], addr_q[n], data_q[n],
                                      exp_addr_q[n], exp_data_q[n], 1'b0);
                OP_DOUBLE: send_rom_word(index_q[n], addr_q[n], data_q[n],
                                         exp_addr_q[n], exp_data_q[n], 1'b1);
                OP_WORM: send_worm_word(index_q[n], addr_q[n], data_q[n],
                                        exp_addr_q[n][`CDI_WORM_ADDR_W-1:0], exp_data_q[n]);
                OP_END: end_download();
                OP_CORE: begin
                    drive_core_write(addr_q[n], data_q[n], exp_addr_q[n], exp_data_q[n]);
                    drive_core_refresh();
                end
                default: abort_run($sformatf("Unknown operation %h on data line %0d",
                                             op_q[n], n + 1));
            endcase
            check_state();
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- all.f
+incdir+include
source/cdi_loader_pkg.sv
source/rom_wr_if.sv
source/download_decoder.sv
source/rom_word_latch.sv
source/prep_sequencer.sv
source/cdi_boot_loader.sv
verif/tb_cdi_boot_loader.sv

//--- Bender.yml
package:
  name: cdi_boot_loader

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/cdi_loader_pkg.sv
      - source/rom_wr_if.sv
      - source/download_decoder.sv
      - source/rom_word_latch.sv
      - source/prep_sequencer.sv
      - source/cdi_boot_loader.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/tb_cdi_boot_loader.sv

//--- verif/cdi_boot_testdata.txt
# Columns in hex: op index addr data exp_addr exp_data
# op 1 start, 2 ROM word, 3 slave word, 4 end, 5 core write, 6 two ROM words back to back
1 0000 0000000 0000 0000000 0000
2 0000 0000000 1234 0400000 3412
2 0000 0000002 abcd 0400002 cdab
3 0040 0000000 5aa5 0000000 5aa5
2 0000 0000004 0f1e 0400004 1e0f
3 0041 0000010 1f2e 0000010 1f2e
2 0000 01ffffe beef 05ffffe efbe
2 0000 0123457 00ff 0523456 ff00
3 0040 0012344 c3d4 0000344 c3d4
2 0001 1c00010 8001 0400010 0180
6 0000 0000100 7777 0400100 7777
4 0000 0000000 0000 0000000 0000
5 0000 0123456 55aa 0123456 55aa
5 0000 1fffffe 0f0f 1fffffe 0f0f
